// ==== src/tag_pkg.sv ====
/*
 * Tag lookup engine shared definitions
 * Widths, command and result structs, configuration selects and status codes
 */
package tag_pkg;

	localparam int num_pu      = 4;
	localparam int pu_id_nbits = 2;
	localparam int tag_nbits   = 16;
	localparam int depth_nbits = 6;
	localparam int value_nbits = 32;

	// Command address that marks a tag lookup
	localparam logic [7:0] tag_lookup_addr = 8'h2c;

	// Hash rules for 64 entries per bank
	//   bank 0 index is key[5:0] ^ key[11:6]
	//   bank 1 index is (key[15:10] ^ key[9:4]) + 1 modulo 64

	typedef struct packed {
		logic                 wr;
		logic [7:0]           addr;
		logic [tag_nbits-1:0] wdata;
	} io_cmd_t;

	typedef struct packed {
		logic                   valid;
		logic [tag_nbits-1:0]   tag;
		logic [depth_nbits-1:0] vidx;
	} tag_entry_t;

	typedef struct packed {
		logic                   valid;
		logic [tag_nbits-1:0]   key;
		logic [pu_id_nbits-1:0] pid;
	} tag_key_t;

	typedef struct packed {
		logic                   valid;
		logic                   hit;
		logic [depth_nbits-1:0] vidx;
		logic [pu_id_nbits-1:0] pid;
	} probe_t;

	typedef enum logic [1:0] {sel_bank0, sel_bank1, sel_value} cfg_sel_t;

	typedef enum logic [1:0] {st_hit0, st_hit1, st_dual, st_miss} tag_status_t;

	typedef struct packed {
		logic                   valid;
		logic [pu_id_nbits-1:0] pid;
		tag_status_t            status;
		logic [value_nbits-1:0] value;
	} tag_result_t;

endpackage

// ==== src/tag_req_arb.sv ====
/*
 * Lookup request arbiter
 * Filters lookup commands, holds one pending flag per PU and grants round robin
 */
module tag_req_arb import tag_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [num_pu-1:0] io_req,
	input  io_cmd_t           io_cmd [num_pu],
	output logic [num_pu-1:0] io_ack,
	output tag_key_t          key
);

	logic [num_pu-1:0]      lookup;
	logic [num_pu-1:0]      pending;
	logic [tag_nbits-1:0]   key_q [num_pu];
	logic [pu_id_nbits-1:0] ptr;
	logic [pu_id_nbits-1:0] idx;
	logic [pu_id_nbits-1:0] gnt_sel;
	logic                   gnt_found;
	logic [num_pu-1:0]      gnt_vec;

	// Only a write to the lookup address counts
	always_comb begin
		for (int i = 0; i < num_pu; i++) begin
			lookup[i] = io_req[i] && io_cmd[i].wr && (io_cmd[i].addr == tag_lookup_addr);
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < num_pu; i++) begin
			if (lookup[i]) begin
				key_q[i] <= io_cmd[i].wdata;
			end
		end
	end

	// Search from ptr upward; walked in reverse so the nearest pending PU wins
	always_comb begin
		gnt_found = 1'b0;
		gnt_sel = ptr;
		idx = ptr;
		for (int i = num_pu - 1; i >= 0; i--) begin
			idx = ptr + pu_id_nbits'(i);
			if (pending[idx]) begin
				gnt_found = 1'b1;
				gnt_sel = idx;
			end
		end
		gnt_vec = gnt_found ? (num_pu'(1) << gnt_sel) : '0;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending <= '0;
			io_ack <= '0;
			ptr <= '0;
		end else begin
			pending <= (pending & ~gnt_vec) | lookup;
			io_ack <= gnt_vec;
			if (gnt_found) begin
				ptr <= gnt_sel + pu_id_nbits'(1);
			end
		end
	end

	// Key leaves in the grant cycle
	assign key = '{valid: gnt_found, key: key_q[gnt_sel], pid: gnt_sel};

endmodule

// ==== src/tag_bank_probe.sv ====
/*
 * Hash table bank probe
 * Hashes the key, reads the bank entry and compares the stored tag
 */
module tag_bank_probe import tag_pkg::*; #(
	parameter int bank = 0
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  tag_key_t               key,
	input  logic                   cfg_wr,
	input  cfg_sel_t               cfg_sel,
	input  logic [depth_nbits-1:0] cfg_addr,
	input  logic [value_nbits-1:0] cfg_wdata,
	output probe_t                 probe
);

	tag_entry_t             mem [2**depth_nbits];
	logic                   cfg_hit;
	logic [depth_nbits-1:0] rd_idx;

	// Read stage
	tag_entry_t             rd_entry;
	logic                   s1_valid;
	logic [tag_nbits-1:0]   s1_key;
	logic [pu_id_nbits-1:0] s1_pid;

	// Compare stage
	logic                   s2_valid;
	logic                   s2_hit;
	logic [depth_nbits-1:0] s2_vidx;
	logic [pu_id_nbits-1:0] s2_pid;

	function automatic logic [depth_nbits-1:0] hash_idx(input logic [tag_nbits-1:0] k);
		if (bank == 0) begin
			return k[5:0] ^ k[11:6];
		end
		// Wraps at 64
		return (k[15:10] ^ k[9:4]) + depth_nbits'(1);
	endfunction

	assign cfg_hit = cfg_wr && (cfg_sel == ((bank == 0) ? sel_bank0 : sel_bank1));

	always_ff @(posedge clk) begin
		if (cfg_hit) begin
			mem[cfg_addr] <= tag_entry_t'(cfg_wdata[$bits(tag_entry_t)-1:0]);
		end
	end

	assign rd_idx = hash_idx(key.key);

	always_ff @(posedge clk) begin
		rd_entry <= mem[rd_idx];
		s1_key <= key.key;
		s1_pid <= key.pid;
	end

	// Hit needs a valid entry and an equal tag
	always_ff @(posedge clk) begin
		s2_hit <= rd_entry.valid && (rd_entry.tag == s1_key);
		s2_vidx <= rd_entry.vidx;
		s2_pid <= s1_pid;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= key.valid;
			s2_valid <= s1_valid;
		end
	end

	assign probe = '{valid: s2_valid, hit: s2_hit, vidx: s2_vidx, pid: s2_pid};

endmodule

// ==== src/tag_result_merge.sv ====
/*
 * Probe merge and value read
 * Picks the winning bank, reads the value memory and builds the lookup result
 */
module tag_result_merge import tag_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  probe_t                 probe0,
	input  probe_t                 probe1,
	input  logic                   cfg_wr,
	input  cfg_sel_t               cfg_sel,
	input  logic [depth_nbits-1:0] cfg_addr,
	input  logic [value_nbits-1:0] cfg_wdata,
	output tag_result_t            result
);

	logic [value_nbits-1:0] vmem [2**depth_nbits];

	logic                   probe_valid;
	logic [depth_nbits-1:0] sel_idx;
	tag_status_t            status;

	// Value read stage
	logic [value_nbits-1:0] rd_value;
	logic                   s1_valid;
	logic [pu_id_nbits-1:0] s1_pid;
	tag_status_t            s1_status;

	// Output stage
	logic                   out_valid;
	logic [pu_id_nbits-1:0] out_pid;
	tag_status_t            out_status;
	logic [value_nbits-1:0] out_value;

	always_ff @(posedge clk) begin
		if (cfg_wr && (cfg_sel == sel_value)) begin
			vmem[cfg_addr] <= cfg_wdata;
		end
	end

	// Both banks run in lockstep
	assign probe_valid = probe0.valid && probe1.valid;

	// Bank 0 wins when both hit
	assign sel_idx = probe0.hit ? probe0.vidx : probe1.vidx;

	always_comb begin
		case ({probe0.hit, probe1.hit})
			2'b11: status = st_dual;
			2'b10: status = st_hit0;
			2'b01: status = st_hit1;
			default: status = st_miss;
		endcase
	end

	always_ff @(posedge clk) begin
		rd_value <= vmem[sel_idx];
		s1_pid <= probe0.pid;
		s1_status <= status;
	end

	always_ff @(posedge clk) begin
		out_pid <= s1_pid;
		out_status <= s1_status;
		out_value <= (s1_status == st_miss) ? '0 : rd_value;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_valid <= probe_valid;
			out_valid <= s1_valid;
		end
	end

	assign result = '{
		valid: out_valid,
		pid: out_pid,
		status: out_status,
		value: out_value
	};

endmodule

// ==== src/tag_lookup_top.sv ====
/*
 * Tag lookup engine top level
 * Arbiter, two hash bank probes and the result merge stage
 */
module tag_lookup_top import tag_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [num_pu-1:0]      io_req,
	input  io_cmd_t                io_cmd [num_pu],
	output logic [num_pu-1:0]      io_ack,
	input  logic                   cfg_wr,
	input  cfg_sel_t               cfg_sel,
	input  logic [depth_nbits-1:0] cfg_addr,
	input  logic [value_nbits-1:0] cfg_wdata,
	output tag_result_t            result
);

	tag_key_t key;
	probe_t   probe0;
	probe_t   probe1;

	tag_req_arb u_tag_req_arb (
		.clk    (clk),
		.rst_n  (rst_n),
		.io_req (io_req),
		.io_cmd (io_cmd),
		.io_ack (io_ack),
		.key    (key)
	);

	// Both banks see the same key in the same cycle
	tag_bank_probe #(.bank(0)) u_tag_bank_probe0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.key       (key),
		.cfg_wr    (cfg_wr),
		.cfg_sel   (cfg_sel),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.probe     (probe0)
	);

	tag_bank_probe #(.bank(1)) u_tag_bank_probe1 (
		.clk       (clk),
		.rst_n     (rst_n),
		.key       (key),
		.cfg_wr    (cfg_wr),
		.cfg_sel   (cfg_sel),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.probe     (probe1)
	);

	tag_result_merge u_tag_result_merge (
		.clk       (clk),
		.rst_n     (rst_n),
		.probe0    (probe0),
		.probe1    (probe1),
		.cfg_wr    (cfg_wr),
		.cfg_sel   (cfg_sel),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.result    (result)
	);

endmodule

// ==== test/tag_lookup_check.sv ====
/*
 * Tag lookup result checker
 * Mirrors the configuration writes, predicts each acked lookup and compares every result
 */
module tag_lookup_check import tag_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [num_pu-1:0]      io_req,
	input  io_cmd_t                io_cmd [num_pu],
	input  logic [num_pu-1:0]      io_ack,
	input  logic                   cfg_wr,
	input  cfg_sel_t               cfg_sel,
	input  logic [depth_nbits-1:0] cfg_addr,
	input  logic [value_nbits-1:0] cfg_wdata,
	input  tag_result_t            result,
	output int                     errors,
	output int                     outstanding
);

	timeunit 1ns;
	timeprecision 1ps;

	tag_entry_t             bank0_sh [64];
	tag_entry_t             bank1_sh [64];
	logic [value_nbits-1:0] value_sh [64];

	// Lookups seen on the strobes and not yet acked
	logic [num_pu-1:0]      req_open;
	logic [tag_nbits-1:0]   req_key [num_pu];
	int                     req_cyc [num_pu];
	tag_result_t            exp_q [num_pu][$];
	int                     due_q [num_pu][$];
	tag_result_t            exp_res;
	int                     exp_due;
	int                     cyc;
	int                     last_ack;
	int                     want;

	function automatic logic [5:0] bank0_index(input logic [15:0] k);
		return k[5:0] ^ k[11:6];
	endfunction

	function automatic logic [5:0] bank1_index(input logic [15:0] k);
		return (k[15:10] ^ k[9:4]) + 6'd1;
	endfunction

	// Expected result of one lookup from the mirrored tables
	function automatic tag_result_t ref_lookup(input logic [15:0] k, input logic [1:0] pid);
		tag_entry_t  e0;
		tag_entry_t  e1;
		logic        h0;
		logic        h1;
		tag_result_t r;
		e0 = bank0_sh[bank0_index(k)];
		e1 = bank1_sh[bank1_index(k)];
		h0 = e0.valid && (e0.tag == k);
		h1 = e1.valid && (e1.tag == k);
		r.valid = 1'b1;
		r.pid = pid;
		r.value = '0;
		if (h0 && h1) begin
			r.status = st_dual;
			r.value = value_sh[e0.vidx];
		end else if (h0) begin
			r.status = st_hit0;
			r.value = value_sh[e0.vidx];
		end else if (h1) begin
			r.status = st_hit1;
			r.value = value_sh[e1.vidx];
		end else begin
			r.status = st_miss;
		end
		return r;
	endfunction

	// First eligible PU after the last one acked
	function automatic int next_grant();
		int q;
		for (int i = 1; i <= num_pu; i++) begin
			q = (last_ack + i) % num_pu;
			if (req_open[q] && req_cyc[q] <= cyc - 2) begin
				return q;
			end
		end
		return -1;
	endfunction

	always @(posedge clk) begin
		if (!rst_n) begin
			errors = 0;
			req_open = '0;
			last_ack = num_pu - 1;
			cyc = 0;
			for (int p = 0; p < num_pu; p++) begin
				exp_q[p].delete();
				due_q[p].delete();
			end
		end else begin
			if (cfg_wr) begin
				case (cfg_sel)
					sel_bank0: bank0_sh[cfg_addr] = cfg_wdata[$bits(tag_entry_t)-1:0];
					sel_bank1: bank1_sh[cfg_addr] = cfg_wdata[$bits(tag_entry_t)-1:0];
					default: value_sh[cfg_addr] = cfg_wdata;
				endcase
			end
			if ($countones(io_ack) > 1) begin
				$display("more than one ack in one cycle at %0t: %b", $time, io_ack);
				errors++;
			end
			for (int p = 0; p < num_pu; p++) begin
				if (io_ack[p] && (!req_open[p] || req_cyc[p] > cyc - 2)) begin
					$display("ack on PU %0d at %0t without a pending lookup", p, $time);
					errors++;
				end else if (io_ack[p]) begin
					want = next_grant();
					if (want != p) begin
						$display("round robin order broken at %0t: PU %0d acked, PU %0d expected",
							$time, p, want);
						errors++;
					end
					exp_q[p].push_back(ref_lookup(req_key[p], 2'(p)));
					// Key went out one cycle before the ack, result four cycles after the key
					due_q[p].push_back(cyc + 3);
					req_open[p] = 1'b0;
					last_ack = p;
				end
			end
			if (result.valid && exp_q[result.pid].size() == 0) begin
				$display("result at %0t for PU %0d with no acked lookup", $time, result.pid);
				errors++;
			end else if (result.valid) begin
				exp_res = exp_q[result.pid].pop_front();
				exp_due = due_q[result.pid].pop_front();
				if (exp_due != cyc) begin
					$display("result for PU %0d at %0t is %0d cycles off the fixed latency",
						result.pid, $time, cyc - exp_due);
					errors++;
				end
				if (result.status != exp_res.status) begin
					$display("mismatch at %0t: result.status expected %0d got %0d",
						$time, exp_res.status, result.status);
					errors++;
				end
				if (result.value != exp_res.value) begin
					$display("mismatch at %0t: result.value expected %h got %h",
						$time, exp_res.value, result.value);
					errors++;
				end
			end
			for (int p = 0; p < num_pu; p++) begin
				if (due_q[p].size() != 0 && due_q[p][0] <= cyc) begin
					$display("no result for PU %0d at %0t when one was due", p, $time);
					errors++;
					exp_q[p].delete(0);
					due_q[p].delete(0);
				end
			end
			for (int p = 0; p < num_pu; p++) begin
				if (io_req[p] && io_cmd[p].wr && io_cmd[p].addr == tag_lookup_addr) begin
					if (req_open[p]) begin
						$display("second lookup from PU %0d at %0t before its ack", p, $time);
						errors++;
					end
					req_open[p] = 1'b1;
					req_key[p] = io_cmd[p].wdata;
					req_cyc[p] = cyc;
				end
			end
			cyc++;
		end
		outstanding = $countones(req_open);
		for (int p = 0; p < num_pu; p++) begin
			outstanding += exp_q[p].size();
		end
	end

endmodule

// ==== test/tag_lookup_tb.sv ====
/*
 * Tag lookup engine testbench
 * Clock, reset, table loading and lookup stimulus around the DUT and its checker
 */
module tag_lookup_tb import tag_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic                   clk;
	logic                   rst_n;
	logic [num_pu-1:0]      io_req;
	io_cmd_t                io_cmd [num_pu];
	logic [num_pu-1:0]      io_ack;
	logic                   cfg_wr;
	cfg_sel_t               cfg_sel;
	logic [depth_nbits-1:0] cfg_addr;
	logic [value_nbits-1:0] cfg_wdata;
	tag_result_t            result;
	int                     chk_errors;
	int                     outstanding;
	int                     wait_fails;
	int                     issued [num_pu];
	int                     acked [num_pu];
	logic [31:0]            lfsr_state;

	tag_lookup_top uut (.*);

	tag_lookup_check chk (.*, .errors(chk_errors), .outstanding(outstanding));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		for (int p = 0; p < num_pu; p++) begin
			if (!rst_n) begin
				acked[p] = 0;
			end else if (io_ack[p]) begin
				acked[p] = acked[p] + 1;
			end
		end
	end

	function automatic logic [5:0] bank0_index(input logic [15:0] k);
		return k[5:0] ^ k[11:6];
	endfunction

	function automatic logic [5:0] bank1_index(input logic [15:0] k);
		return (k[15:10] ^ k[9:4]) + 6'd1;
	endfunction

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic coin();
		return 1'(take_bits(1));
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic cfg_write(input cfg_sel_t sel, input logic [5:0] addr, input logic [31:0] data);
		cfg_wr = 1'b1;
		cfg_sel = sel;
		cfg_addr = addr;
		cfg_wdata = data;
		tick();
		cfg_wr = 1'b0;
	endtask

	task automatic store_entry(input cfg_sel_t sel, input logic [15:0] k, input logic [5:0] vidx);
		tag_entry_t e;
		e = '{valid: 1'b1, tag: k, vidx: vidx};
		cfg_write(sel, (sel == sel_bank0) ? bank0_index(k) : bank1_index(k), 32'(e));
	endtask

	task automatic set_lookup(input int p, input logic [15:0] k);
		io_req[p] = 1'b1;
		io_cmd[p] = '{wr: 1'b1, addr: tag_lookup_addr, wdata: k};
		issued[p]++;
	endtask

	task automatic set_other(input int p, input logic wr, input logic [7:0] addr,
		input logic [15:0] d);
		io_req[p] = 1'b1;
		io_cmd[p] = '{wr: wr, addr: addr, wdata: d};
	endtask

	task automatic strobe();
		tick();
		io_req = '0;
	endtask

	task automatic wait_pu_free(input int p);
		int n;
		n = 0;
		while (issued[p] != acked[p] && n < 200) begin
			tick();
			n++;
		end
		if (issued[p] != acked[p]) begin
			$display("timeout waiting for the ack of PU %0d", p);
			wait_fails++;
			issued[p] = acked[p];
		end
	endtask

	task automatic lookup(input int p, input logic [15:0] k);
		wait_pu_free(p);
		set_lookup(p, k);
		strobe();
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (outstanding != 0 && n < 200) begin
			tick();
			n++;
		end
		if (outstanding != 0) begin
			$display("timeout waiting for %0d lookups to finish", outstanding);
			wait_fails++;
		end
	endtask

	initial begin
		logic [15:0] stored [$];
		logic [15:0] k;
		rst_n = 1'b0;
		io_req = '0;
		cfg_wr = 1'b0;
		cfg_sel = sel_bank0;
		cfg_addr = '0;
		cfg_wdata = '0;
		wait_fails = 0;
		lfsr_state = 32'hed5c;
		for (int p = 0; p < num_pu; p++) begin
			io_cmd[p] = '0;
			issued[p] = 0;
		end
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Empty banks and value words tied to the whole address
		for (int a = 0; a < 64; a++) begin
			cfg_write(sel_bank0, 6'(a), '0);
			cfg_write(sel_bank1, 6'(a), '0);
			cfg_write(sel_value, 6'(a), 32'h9e37_79b9 * (32'(a) + 32'd1));
		end
		store_entry(sel_bank0, 16'h1234, 6'd5);
		store_entry(sel_bank1, 16'hbeef, 6'd9);
		store_entry(sel_bank0, 16'h0f0f, 6'd12);
		store_entry(sel_bank1, 16'h0f0f, 6'd20);
		lookup(0, 16'h1234);
		lookup(1, 16'hbeef);
		lookup(2, 16'h0f0f);
		lookup(3, 16'(take_bits(16)));
		drain();

		// Full bursts that start from a different pointer each time
		for (int b = 0; b < 2; b++) begin
			lookup(b, 16'h1234);
			drain();
			set_lookup(0, 16'h0f0f);
			set_lookup(1, 16'h1234);
			set_lookup(2, 16'(take_bits(16)));
			set_lookup(3, 16'hbeef);
			strobe();
			drain();
		end

		// Strobes that are not lookups mixed with real ones
		set_other(0, 1'b0, tag_lookup_addr, 16'h1234);
		set_other(1, 1'b1, tag_lookup_addr ^ 8'h01, 16'hbeef);
		set_lookup(2, 16'h0f0f);
		set_other(3, 1'b1, 8'h00, 16'h1234);
		strobe();
		set_lookup(0, 16'hbeef);
		set_other(1, 1'b0, 8'h00, 16'h0f0f);
		set_other(2, 1'b0, tag_lookup_addr, 16'hbeef);
		strobe();
		drain();

		for (int i = 0; i < 32; i++) begin
			k = 16'(take_bits(16));
			store_entry(coin() ? sel_bank1 : sel_bank0, k, 6'(take_bits(6)));
			stored.push_back(k);
		end
		for (int i = 0; i < 400; i++) begin
			for (int p = 0; p < num_pu; p++) begin
				if (issued[p] == acked[p] && coin()) begin
					k = coin() ? stored[take_bits(5)] : 16'(take_bits(16));
					set_lookup(p, k);
				end
			end
			strobe();
		end
		drain();

		if (outstanding != 0) begin
			$display("%0d lookups still outstanding at the end of the test", outstanding);
			wait_fails++;
		end
		$display("errors: %0d from the checker, %0d wait failures", chk_errors, wait_fails);
		if (chk_errors == 0 && wait_fails == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== tag_lookup.f ====
src/tag_pkg.sv
src/tag_req_arb.sv
src/tag_bank_probe.sv
src/tag_result_merge.sv
src/tag_lookup_top.sv
test/tag_lookup_check.sv
test/tag_lookup_tb.sv

// ==== Makefile ====
# Verilator build and run of the tag lookup engine testbench

VERILATOR ?= verilator
TOP       ?= tag_lookup_tb
FILELIST  ?= tag_lookup.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) into $(LOG), search it for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '^RESULT: PASS$$' $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
